// File: Bender.yml
package:
  name: csr_bank

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_sel_if.sv
  - rtl/csr_decode.sv
  - rtl/csr_regs.sv
  - rtl/csr_irq_ctrl.sv
  - rtl/csr_read_mux.sv
  - rtl/csr_bank.sv
  - target: test
    files:
      - tests/csr_bank_asserts.sv
      - tests/csr_bank_tb.sv

// File: files.f
rtl/csr_pkg.sv
rtl/csr_sel_if.sv
rtl/csr_decode.sv
rtl/csr_regs.sv
rtl/csr_irq_ctrl.sv
rtl/csr_read_mux.sv
rtl/csr_bank.sv
tests/csr_bank_asserts.sv
tests/csr_bank_tb.sv

// File: rtl/csr_bank.sv
/*
 * Machine-mode CSR bank top level. Decode, register execute stage,
 * read mux and interrupt control.
 */

module csr_bank #(
    parameter csr_pkg::csr_word_t hart_id = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 read_enable_i,
    input  logic                 write_enable_i,
    input  logic                 killed_i,
    input  csr_pkg::csr_op_e     operation_i,
    input  csr_pkg::csr_addr_e   address_i,
    input  csr_pkg::csr_word_t   data_i,
    input  logic                 raise_exception_i,
    input  logic                 machine_return_i,
    input  csr_pkg::exc_code_e   exception_code_i,
    input  csr_pkg::csr_word_t   pc_i,
    input  csr_pkg::csr_word_t   instruction_i,
    input  csr_pkg::csr_word_t   irq_i,
    input  logic                 interrupt_ack_i,
    output csr_pkg::csr_word_t   read_data_o,
    output logic                 interrupt_pending_o,
    output csr_pkg::priv_e       privilege_o,
    output csr_pkg::csr_word_t   mepc_o,
    output csr_pkg::csr_word_t   mtvec_o
);
    import csr_pkg::*;

    csr_word_t mstatus, misa, mie, mscratch, mcause, mtval, mip;
    irq_code_e irq_code;

    csr_sel_if u_sel ();

    csr_decode u_decode (
        .address_i (address_i),
        .sel_o     (u_sel.dec)
    );

    //////////////////////////////
    // Execute stage
    //////////////////////////////

    csr_regs u_regs (
        .clk               (clk),
        .reset             (reset),
        .sel_i             (u_sel.exe),
        .write_enable_i    (write_enable_i),
        .killed_i          (killed_i),
        .operation_i       (operation_i),
        .data_i            (data_i),
        .raise_exception_i (raise_exception_i),
        .exception_code_i  (exception_code_i),
        .pc_i              (pc_i),
        .instruction_i     (instruction_i),
        .machine_return_i  (machine_return_i),
        .interrupt_ack_i   (interrupt_ack_i),
        .irq_code_i        (irq_code),
        .mstatus_o         (mstatus),
        .misa_o            (misa),
        .mie_o             (mie),
        .mtvec_o           (mtvec_o),
        .mscratch_o        (mscratch),
        .mepc_o            (mepc_o),
        .mcause_o          (mcause),
        .mtval_o           (mtval),
        .privilege_o       (privilege_o)
    );

    csr_irq_ctrl u_irq (
        .clk                 (clk),
        .reset               (reset),
        .irq_i               (irq_i),
        .interrupt_ack_i     (interrupt_ack_i),
        .mstatus_i           (mstatus),
        .mie_i               (mie),
        .mip_o               (mip),
        .irq_code_o          (irq_code),
        .interrupt_pending_o (interrupt_pending_o)
    );

    csr_read_mux #(
        .hart_id (hart_id)
    ) u_read (
        .sel_i         (u_sel.res),
        .read_enable_i (read_enable_i),
        .killed_i      (killed_i),
        .mstatus_i     (mstatus),
        .misa_i        (misa),
        .mie_i         (mie),
        .mtvec_i       (mtvec_o),
        .mscratch_i    (mscratch),
        .mepc_i        (mepc_o),
        .mcause_i      (mcause),
        .mtval_i       (mtval),
        .mip_i         (mip),
        .read_data_o   (read_data_o)
    );

endmodule

// File: rtl/csr_decode.sv
/*
 * CSR address decode into register index, write mask and access flags
 */

module csr_decode (
    input  csr_pkg::csr_addr_e address_i,
    csr_sel_if.dec             sel_o
);
    import csr_pkg::*;

    csr_word_t wmask;

    always_comb begin
        sel_o.sel      = SEL_NONE;
        wmask          = '0;
        sel_o.readable = 1'b1;
        case (address_i)
            CSR_MVENDORID,
            CSR_MARCHID,
            CSR_MIMPID:   sel_o.sel = SEL_ID_ZERO;   // Read-only, reads zero
            CSR_MHARTID:  sel_o.sel = SEL_HARTID;
            CSR_MSTATUS: begin
                sel_o.sel = SEL_MSTATUS;
                wmask     = MSTATUS_WMASK;
            end
            CSR_MISA: begin
                sel_o.sel = SEL_MISA;
                wmask     = MISA_WMASK;
            end
            CSR_MIE: begin
                sel_o.sel = SEL_MIE;
                wmask     = MIE_WMASK;
            end
            CSR_MTVEC: begin
                sel_o.sel = SEL_MTVEC;
                wmask     = MTVEC_WMASK;
            end
            CSR_MSCRATCH: begin
                sel_o.sel = SEL_MSCRATCH;
                wmask     = MSCRATCH_WMASK;
            end
            CSR_MEPC: begin
                sel_o.sel = SEL_MEPC;
                wmask     = MEPC_WMASK;
            end
            CSR_MCAUSE: begin
                sel_o.sel = SEL_MCAUSE;
                wmask     = MCAUSE_WMASK;
            end
            CSR_MTVAL: begin
                sel_o.sel = SEL_MTVAL;
                wmask     = MTVAL_WMASK;
            end
            CSR_MIP:      sel_o.sel = SEL_MIP;       // Follows irq lines only
            default:      sel_o.readable = 1'b0;
        endcase
    end

    assign sel_o.wmask    = wmask;
    assign sel_o.writable = (wmask != '0);

endmodule

// File: rtl/csr_irq_ctrl.sv
/*
 * Interrupt line sampling into mip, pending flag and cause priority
 */

module csr_irq_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  csr_pkg::csr_word_t  irq_i,
    input  logic                interrupt_ack_i,
    input  csr_pkg::csr_word_t  mstatus_i,
    input  csr_pkg::csr_word_t  mie_i,
    output csr_pkg::csr_word_t  mip_o,
    output csr_pkg::irq_code_e  irq_code_o,
    output logic                interrupt_pending_o
);
    import csr_pkg::*;

    mstatus_u  status;
    csr_word_t active;

    assign status = mstatus_i;
    assign active = mie_i & mip_o;     // Enabled and pending lines

    // First stage
    always_ff @(posedge clk) begin
        if (reset) begin
            mip_o <= '0;
        end else begin
            mip_o <= irq_i;
        end
    end

    // Second stage, external before software before timer
    always_ff @(posedge clk) begin
        if (reset) begin
            interrupt_pending_o <= 1'b0;
            irq_code_o          <= IRQ_SOFTWARE;
        end else if (status.f.mie && active != '0 && !interrupt_ack_i) begin
            interrupt_pending_o <= 1'b1;
            if (active[11])
                irq_code_o <= IRQ_EXTERNAL;
            else if (active[3])
                irq_code_o <= IRQ_SOFTWARE;
            else if (active[7])
                irq_code_o <= IRQ_TIMER;
        end else begin
            interrupt_pending_o <= 1'b0;   // Cause holds its last value
        end
    end

endmodule

// File: rtl/csr_pkg.sv
/*
 * CSR bank package. Addresses, operations, trap and interrupt codes,
 * privilege levels, the word type, the mstatus layout and write masks.
 */

package csr_pkg;

    typedef logic [31:0] csr_word_t;

    typedef enum logic [11:0] {
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14,
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MSCRATCH  = 12'h340,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344
    } csr_addr_e;

    // Low bits of the csrrw/csrrs/csrrc funct3
    typedef enum logic [1:0] {
        OP_WRITE = 2'd1,
        OP_SET   = 2'd2,
        OP_CLEAR = 2'd3
    } csr_op_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'd0,
        PRIV_MACHINE = 2'd3
    } priv_e;

    typedef enum logic [4:0] {
        EXC_INSTR_MISALIGNED = 5'd0,
        EXC_ILLEGAL_INSTR    = 5'd2,
        EXC_BREAKPOINT       = 5'd3,
        EXC_ECALL_M          = 5'd11
    } exc_code_e;

    typedef enum logic [4:0] {
        IRQ_SOFTWARE = 5'd3,
        IRQ_TIMER    = 5'd7,
        IRQ_EXTERNAL = 5'd11
    } irq_code_e;

    // Internal register index, shared by decode, execute and read
    typedef enum logic [3:0] {
        SEL_NONE, SEL_ID_ZERO, SEL_HARTID, SEL_MSTATUS, SEL_MISA, SEL_MIE,
        SEL_MTVEC, SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MIP
    } csr_sel_e;

    typedef union packed {
        csr_word_t raw;
        struct packed {
            logic [18:0] rsvd_hi;
            priv_e       mpp;       // Bits 12:11
            logic [2:0]  rsvd_mid;
            logic        mpie;      // Bit 7
            logic [2:0]  rsvd_ie;
            logic        mie;       // Bit 3
            logic [2:0]  rsvd_lo;
        } f;
    } mstatus_u;

    localparam csr_word_t MSTATUS_WMASK  = 32'h007E19AA;
    localparam csr_word_t MISA_WMASK     = 32'h3C000000;
    localparam csr_word_t MIE_WMASK      = 32'h00000888;
    localparam csr_word_t MTVEC_WMASK    = 32'hFFFFFFFC;
    localparam csr_word_t MEPC_WMASK     = 32'hFFFFFFFC;
    localparam csr_word_t MSCRATCH_WMASK = 32'hFFFFFFFF;
    localparam csr_word_t MCAUSE_WMASK   = 32'hFFFFFFFF;
    localparam csr_word_t MTVAL_WMASK    = 32'hFFFFFFFF;

    localparam csr_word_t MISA_RESET     = 32'h40000100;   // RV32I

endpackage

// File: rtl/csr_read_mux.sv
/*
 * CSR read data selection with read gating
 */

module csr_read_mux #(
    parameter csr_pkg::csr_word_t hart_id = '0
) (
    csr_sel_if.res               sel_i,
    input  logic                 read_enable_i,
    input  logic                 killed_i,
    input  csr_pkg::csr_word_t   mstatus_i,
    input  csr_pkg::csr_word_t   misa_i,
    input  csr_pkg::csr_word_t   mie_i,
    input  csr_pkg::csr_word_t   mtvec_i,
    input  csr_pkg::csr_word_t   mscratch_i,
    input  csr_pkg::csr_word_t   mepc_i,
    input  csr_pkg::csr_word_t   mcause_i,
    input  csr_pkg::csr_word_t   mtval_i,
    input  csr_pkg::csr_word_t   mip_i,
    output csr_pkg::csr_word_t   read_data_o
);
    import csr_pkg::*;

    always_comb begin
        read_data_o = '0;
        if (read_enable_i && !killed_i && sel_i.readable) begin
            case (sel_i.sel)
                SEL_HARTID:   read_data_o = hart_id;
                SEL_MSTATUS:  read_data_o = mstatus_i;
                SEL_MISA:     read_data_o = misa_i;
                SEL_MIE:      read_data_o = mie_i;
                SEL_MTVEC:    read_data_o = mtvec_i;
                SEL_MSCRATCH: read_data_o = mscratch_i;
                SEL_MEPC:     read_data_o = mepc_i;
                SEL_MCAUSE:   read_data_o = mcause_i;
                SEL_MTVAL:    read_data_o = mtval_i;
                SEL_MIP:      read_data_o = mip_i;
                default:      read_data_o = '0;     // Identity regs read zero
            endcase
        end
    end

endmodule

// File: rtl/csr_regs.sv
/*
 * Writable machine-mode CSRs with masked write, set and clear,
 * trap entry on exception or interrupt, and mret
 */

module csr_regs (
    input  logic                 clk,
    input  logic                 reset,
    csr_sel_if.exe               sel_i,
    input  logic                 write_enable_i,
    input  logic                 killed_i,
    input  csr_pkg::csr_op_e     operation_i,
    input  csr_pkg::csr_word_t   data_i,
    input  logic                 raise_exception_i,
    input  csr_pkg::exc_code_e   exception_code_i,
    input  csr_pkg::csr_word_t   pc_i,
    input  csr_pkg::csr_word_t   instruction_i,
    input  logic                 machine_return_i,
    input  logic                 interrupt_ack_i,
    input  csr_pkg::irq_code_e   irq_code_i,
    output csr_pkg::csr_word_t   mstatus_o,
    output csr_pkg::csr_word_t   misa_o,
    output csr_pkg::csr_word_t   mie_o,
    output csr_pkg::csr_word_t   mtvec_o,
    output csr_pkg::csr_word_t   mscratch_o,
    output csr_pkg::csr_word_t   mepc_o,
    output csr_pkg::csr_word_t   mcause_o,
    output csr_pkg::csr_word_t   mtval_o,
    output csr_pkg::priv_e       privilege_o
);
    import csr_pkg::*;

    mstatus_u  mstatus;
    csr_word_t misa, mie, mtvec, mscratch, mepc, mcause, mtval;
    csr_word_t current_val, wr_data;
    logic      write_allowed;

    assign write_allowed = write_enable_i && !killed_i && sel_i.writable;

    always_comb begin
        case (sel_i.sel)
            SEL_MSTATUS:  current_val = mstatus.raw;
            SEL_MISA:     current_val = misa;
            SEL_MIE:      current_val = mie;
            SEL_MTVEC:    current_val = mtvec;
            SEL_MSCRATCH: current_val = mscratch;
            SEL_MEPC:     current_val = mepc;
            SEL_MCAUSE:   current_val = mcause;
            SEL_MTVAL:    current_val = mtval;
            default:      current_val = '0;
        endcase
    end

    always_comb begin
        case (operation_i)
            OP_SET:   wr_data = (current_val | data_i) & sel_i.wmask;
            OP_CLEAR: wr_data = (current_val & ~data_i) & sel_i.wmask;
            default:  wr_data = data_i & sel_i.wmask;
        endcase
    end

    //////////////////////////////
    // Register update
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus.raw    <= '0;
            mstatus.f.mpp  <= PRIV_MACHINE;
            misa           <= MISA_RESET;
            mie            <= '0;
            mtvec          <= '0;
            mscratch       <= '0;
            mepc           <= '0;
            mcause         <= '0;
            mtval          <= '0;
            privilege_o    <= PRIV_MACHINE;
        end else if (machine_return_i) begin
            mstatus.f.mie  <= mstatus.f.mpie;
            privilege_o    <= mstatus.f.mpp;       // Back to the trapped level
        end else if (raise_exception_i || interrupt_ack_i) begin
            mstatus.f.mpp  <= privilege_o;
            mstatus.f.mpie <= mstatus.f.mie;
            mstatus.f.mie  <= 1'b0;                // Traps enter with irqs off
            privilege_o    <= PRIV_MACHINE;
            if (raise_exception_i) begin
                mcause <= {1'b0, 26'b0, exception_code_i};
                if (exception_code_i == EXC_ECALL_M || exception_code_i == EXC_BREAKPOINT)
                    mepc <= pc_i;
                else
                    mepc <= pc_i + 32'd4;
                if (exception_code_i == EXC_ILLEGAL_INSTR)
                    mtval <= instruction_i;        // Faulting encoding
                else
                    mtval <= pc_i;
            end else begin
                mcause <= {1'b1, 26'b0, irq_code_i};
                mepc   <= pc_i;                    // Resume at the interrupted pc
            end
        end else if (write_allowed) begin
            case (sel_i.sel)
                SEL_MSTATUS:  mstatus.raw <= wr_data;
                SEL_MISA:     misa        <= wr_data;
                SEL_MIE:      mie         <= wr_data;
                SEL_MTVEC:    mtvec       <= wr_data;
                SEL_MSCRATCH: mscratch    <= wr_data;
                SEL_MEPC:     mepc        <= wr_data;
                SEL_MCAUSE:   mcause      <= wr_data;
                SEL_MTVAL:    mtval       <= wr_data;
                default: ;
            endcase
        end
    end

    // Snapshot for read mux and interrupt control
    assign mstatus_o  = mstatus.raw;
    assign misa_o     = misa;
    assign mie_o      = mie;
    assign mtvec_o    = mtvec;
    assign mscratch_o = mscratch;
    assign mepc_o     = mepc;
    assign mcause_o   = mcause;
    assign mtval_o    = mtval;

endmodule

// File: rtl/csr_sel_if.sv
/*
 * Decoded CSR selection between decode, execute and read stages
 */

interface csr_sel_if;
    import csr_pkg::*;

    csr_sel_e  sel;
    csr_word_t wmask;
    logic      writable;    // Mask has at least one bit set
    logic      readable;    // Address is implemented

    modport dec (output sel, output wmask, output writable, output readable);

    modport exe (input sel, input wmask, input writable);

    modport res (input sel, input readable);

endinterface

// File: tests/csr_bank_asserts.sv
/*
 * Concurrent checks on the CSR bank ports, bound into csr_bank
 */

module csr_bank_asserts (
    input logic               clk,
    input logic               reset,
    input logic               read_enable_i,
    input logic               raise_exception_i,
    input logic               interrupt_ack_i,
    input csr_pkg::csr_word_t read_data_o,
    input csr_pkg::priv_e     privilege_o,
    input logic               interrupt_pending_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    int unsigned fail_count = 0;    // Failed assertions so far

    a_read_gated: assert property (@(posedge clk) disable iff (reset)
        !read_enable_i |-> read_data_o == '0)
        else begin
            fail_count++;
            $error("read data is not zero while read enable is low");
        end

    // Trap entry always lands in machine mode
    a_trap_machine: assert property (@(posedge clk) disable iff (reset)
        raise_exception_i |=> privilege_o == PRIV_MACHINE)
        else begin
            fail_count++;
            $error("privilege is not machine after an exception");
        end

    a_ack_clears: assert property (@(posedge clk) disable iff (reset)
        interrupt_ack_i |=> !interrupt_pending_o)
        else begin
            fail_count++;
            $error("interrupt still pending after acknowledge");
        end

endmodule

bind csr_bank csr_bank_asserts u_asserts (
    .clk                 (clk),
    .reset               (reset),
    .read_enable_i       (read_enable_i),
    .raise_exception_i   (raise_exception_i),
    .interrupt_ack_i     (interrupt_ack_i),
    .read_data_o         (read_data_o),
    .privilege_o         (privilege_o),
    .interrupt_pending_o (interrupt_pending_o)
);

// File: tests/csr_bank_tb.sv
/*
 * CSR bank testbench. Reads the case file, drives the DUT on the
 * falling clock edge, checks read data, the mepc and mtvec ports,
 * privilege and pending flag, and runs a watchdog.
 */

module csr_bank_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import csr_pkg::*;

    localparam csr_word_t HART_ID    = 32'h00000005;
    localparam int        CLK_PERIOD = 100;

    logic      clk = 1'b0;
    logic      reset;
    logic      read_enable, write_enable, killed;
    csr_op_e   operation;
    csr_addr_e address;
    csr_word_t data, pc, instruction, irq;
    logic      raise_exception, machine_return, interrupt_ack;
    exc_code_e exception_code;
    csr_word_t read_data, mepc, mtvec;
    logic      interrupt_pending;
    priv_e     privilege;

    // One entry per case line
    string     case_name[$];
    string     case_action[$];
    csr_word_t case_op[$], case_addr[$], case_data[$], case_pc[$], case_code[$], case_exp[$];
    int        num_cases    = 0;
    logic      cases_loaded = 1'b0;
    csr_word_t lfsr_state   = 32'hd891;

    always #(CLK_PERIOD / 2) clk = ~clk;

    csr_bank #(
        .hart_id (HART_ID)
    ) u_dut (
        .clk                 (clk),
        .reset               (reset),
        .read_enable_i       (read_enable),
        .write_enable_i      (write_enable),
        .killed_i            (killed),
        .operation_i         (operation),
        .address_i           (address),
        .data_i              (data),
        .raise_exception_i   (raise_exception),
        .machine_return_i    (machine_return),
        .exception_code_i    (exception_code),
        .pc_i                (pc),
        .instruction_i       (instruction),
        .irq_i               (irq),
        .interrupt_ack_i     (interrupt_ack),
        .read_data_o         (read_data),
        .interrupt_pending_o (interrupt_pending),
        .privilege_o         (privilege),
        .mepc_o              (mepc),
        .mtvec_o             (mtvec)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Galois LFSR, taps 32, 22, 2, 1
    function automatic csr_word_t lfsr_step(input csr_word_t s);
        if (s[0])
            return (s >> 1) ^ 32'h80200003;
        return s >> 1;
    endfunction

    function automatic csr_word_t random_word();
        csr_word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};   // One step per bit
        end
        return w;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input csr_word_t expected,
                              input csr_word_t actual);
        if (actual !== expected)
            abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    endtask

    task automatic check_priv(input string name, input priv_e expected, input priv_e actual);
        if (actual !== expected)
            abort_run($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abort_run($sformatf("Error: %s expected %b actual %b", name, expected, actual));
    endtask

    task automatic load_cases();
        int        fd, n;
        string     line, name, action;
        csr_word_t op, addr, value, pc_val, code, expected;
        fd = $fopen("tests/csr_cases.txt", "r");
        if (fd == 0)
            abort_run("Could not open the case file tests/csr_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#")   // Blank or comment
                continue;
            n = $sscanf(line, "%s %s %h %h %h %h %h %h",
                        name, action, op, addr, value, pc_val, code, expected);
            if (n != 8)
                abort_run({"Malformed line in the case file: ", line});
            case_name.push_back(name);
            case_action.push_back(action);
            case_op.push_back(op);
            case_addr.push_back(addr);
            case_data.push_back(value);
            case_pc.push_back(pc_val);
            case_code.push_back(code);
            case_exp.push_back(expected);
        end
        $fclose(fd);
    endtask

    task automatic clear_strobes();
        write_enable    = 1'b0;
        killed          = 1'b0;
        raise_exception = 1'b0;
        machine_return  = 1'b0;
        interrupt_ack   = 1'b0;
    endtask

    task automatic run_case(input int i);
        string     name;
        string     action;
        csr_word_t expected;
        name     = case_name[i];
        action   = case_action[i];
        expected = case_exp[i];
        @(negedge clk);
        operation      = csr_op_e'(case_op[i][1:0]);
        address        = csr_addr_e'(case_addr[i][11:0]);
        data           = case_data[i];
        instruction    = case_data[i];
        pc             = case_pc[i];
        exception_code = exc_code_e'(case_code[i][4:0]);
        case (action)
            "rd":   read_enable = 1'b1;
            "nrd":  read_enable = 1'b0;
            "wr":   write_enable = 1'b1;
            "kwr": begin
                write_enable = 1'b1;
                killed       = 1'b1;
            end
            "rnd": begin
                data         = random_word();
                expected     = data & case_exp[i];   // Column holds the write mask
                write_enable = 1'b1;
            end
            "exc":  raise_exception = 1'b1;
            "mret": machine_return = 1'b1;
            "irq":  irq = case_data[i];
            "ack":  interrupt_ack = 1'b1;
            default: abort_run({"Unknown action in case ", name});
        endcase
        if (action != "rd" && action != "nrd") begin
            @(negedge clk);            // One rising edge has passed
            clear_strobes();
            read_enable = 1'b1;        // Read back the same address
        end
        #(CLK_PERIOD / 4);
        case (action)
            "exc", "mret": check_priv(name, priv_e'(expected[1:0]), privilege);
            "ack":         check_bit(name, expected[0], interrupt_pending);
            "irq": begin
                check_bit({name, " after one edge"}, 1'b0, interrupt_pending);
                @(negedge clk);
                #(CLK_PERIOD / 4);
                check_bit(name, expected[0], interrupt_pending);
            end
            default: begin
                check_word(name, expected, read_data);
                if (read_enable && address == CSR_MEPC)    // Direct port view
                    check_word({name, " mepc_o"}, expected, mepc);
                if (read_enable && address == CSR_MTVEC)
                    check_word({name, " mtvec_o"}, expected, mtvec);
            end
        endcase
    endtask

    //////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////

    initial begin
        reset          = 1'b1;
        read_enable    = 1'b0;
        operation      = OP_WRITE;
        address        = CSR_MSTATUS;
        data           = '0;
        pc             = '0;
        instruction    = '0;
        irq            = '0;
        exception_code = EXC_INSTR_MISALIGNED;
        clear_strobes();
        load_cases();
        num_cases    = case_name.size();
        cases_loaded = 1'b1;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_cases; i++)
            run_case(i);
        if (u_dut.u_asserts.fail_count != 0) begin
            abort_run("A bound assertion on the DUT ports failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    // Port assertions stop the run at their first failure
    always @(negedge clk) begin
        if (u_dut.u_asserts.fail_count != 0)
            abort_run("A bound assertion on the DUT ports failed");
    end

    initial begin
        wait (cases_loaded);
        #((num_cases * 4 + 20) * CLK_PERIOD);
        abort_run("Timeout: the cases did not finish in the expected time");
    end

endmodule

// File: tests/csr_cases.txt
# name action op addr data pc code expected (all hex)
# data is data_i, instruction_i or irq_i; for rnd the expected column is the write mask
rst_mstatus     rd   0 300 00000000 00000000 00 00001800
rst_misa        rd   0 301 00000000 00000000 00 40000100
rst_mie         rd   0 304 00000000 00000000 00 00000000
hartid          rd   0 F14 00000000 00000000 00 00000005
vendorid        rd   0 F11 00000000 00000000 00 00000000
unimpl_rd       rd   0 7C0 00000000 00000000 00 00000000
rnd_mscratch_a  rnd  1 340 00000000 00000000 00 FFFFFFFF
rnd_mscratch_b  rnd  1 340 00000000 00000000 00 FFFFFFFF
rnd_mie         rnd  1 304 00000000 00000000 00 00000888
rnd_mtvec       rnd  1 305 00000000 00000000 00 FFFFFFFC
rnd_misa        rnd  1 301 00000000 00000000 00 3C000000
ones_mie        wr   1 304 FFFFFFFF 00000000 00 00000888
ones_mtvec      wr   1 305 FFFFFFFF 00000000 00 FFFFFFFC
ones_misa       wr   1 301 FFFFFFFF 00000000 00 3C000000
ones_mscratch   wr   1 340 FFFFFFFF 00000000 00 FFFFFFFF
wr_mie          wr   1 304 00000080 00000000 00 00000080
set_mie         wr   2 304 00000009 00000000 00 00000088
clr_mie         wr   3 304 00000080 00000000 00 00000008
wr_mscratch     wr   1 340 12345678 00000000 00 12345678
set_mscratch    wr   2 340 F0000000 00000000 00 F2345678
clr_mscratch    wr   3 340 00000078 00000000 00 F2345600
killed_mscratch kwr  1 340 FFFFFFFF 00000000 00 F2345600
killed_mie      kwr  1 304 00000800 00000000 00 00000008
noread_mscratch nrd  0 340 00000000 00000000 00 00000000
wr_mstatus_user wr   1 300 00000088 00000000 00 00000088
mret_to_user    mret 0 300 00000000 00000000 00 00000000
mret_mstatus    rd   0 300 00000000 00000000 00 00000088
exc_illegal     exc  0 300 DEADBEEF 00001000 02 00000003
illegal_mcause  rd   0 342 00000000 00000000 00 00000002
illegal_mepc    rd   0 341 00000000 00000000 00 00001004
illegal_mtval   rd   0 343 00000000 00000000 00 DEADBEEF
illegal_mstatus rd   0 300 00000000 00000000 00 00000080
exc_ecall       exc  0 300 00000000 00002000 0B 00000003
ecall_mcause    rd   0 342 00000000 00000000 00 0000000B
ecall_mepc      rd   0 341 00000000 00000000 00 00002000
ecall_mtval     rd   0 343 00000000 00000000 00 00002000
ecall_mstatus   rd   0 300 00000000 00000000 00 00001800
mret_to_machine mret 0 300 00000000 00000000 00 00000003
irq_mstatus     wr   1 300 00000008 00000000 00 00000008
irq_mie         wr   1 304 00000888 00000000 00 00000888
irq_pending     irq  0 300 00000888 00000000 00 00000001
irq_ack         ack  0 300 00000000 00003000 00 00000000
ack_mcause      rd   0 342 00000000 00000000 00 8000000B
ack_mepc        rd   0 341 00000000 00000000 00 00003000
ack_mstatus     rd   0 300 00000000 00000000 00 00001880
ack_mip         rd   0 344 00000000 00000000 00 00000888
